/* all.f */
common/ntm_fixed_pkg.sv
common/ntm_state_pkg.sv
design/ntm_scalar_multiplier.sv
design/ntm_scalar_modular_reduce.sv
oneplus/ntm_scalar_oneplus_function.sv
oneplus/ntm_vector_oneplus_function.sv
design/ntm_oneplus_top.sv
verif/ntm_oneplus_props.sv
verif/ntm_oneplus_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the oneplus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module ntm_oneplus_tb \
  -f all.f

# A crashing or stopped run still falls through to the search below
output=$(./obj_dir/Vntm_oneplus_tb) || true
echo "$output"

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
else
  exit 1
fi

/* verif/ntm_oneplus_tb.sv */
/*
  Table-driven testbench for the oneplus vector subsystem at DATA_SIZE 16
  Expected values follow the quadratic softplus rule and the modular reduction
  Elements of one vector share SIZE_IN and MODULO_IN, one element in flight
*/

`timescale 1ns/100ps

module ntm_oneplus_tb;

  ////////////////////////////////////////////////////////////
  // Test dimensions
  ////////////////////////////////////////////////////////////

  localparam int DATA_SIZE      = 16;
  localparam int TABLE_ROWS     = 20;
  localparam int RANDOM_ROWS    = 12;
  localparam int RANDOM_LEN     = 4;
  localparam int NUM_ELEMS      = TABLE_ROWS + RANDOM_ROWS;
  localparam int NUM_VECTORS    = 6 + RANDOM_ROWS / RANDOM_LEN;
  localparam int TIMEOUT_CYCLES = NUM_ELEMS * (2 * DATA_SIZE + 12) + 64;

  // Fixed-point constants of the rule
  localparam int FRAC     = ntm_fixed_pkg::FRAC_BITS;
  localparam int BOUND_FX = ntm_fixed_pkg::BOUND_INT << FRAC;
  localparam int ONE_FX   = ntm_fixed_pkg::ONE_INT << FRAC;

  // Row layout: vector id, SIZE_IN, MODULO_IN, DATA_IN
  localparam logic [55:0] STIM_TABLE [TABLE_ROWS] = '{
    56'h00_0004_0000_0000, 56'h00_0004_0000_0180, 56'h00_0004_0000_FE80,
    56'h00_0004_0000_03E6,
    56'h01_0001_0000_0400,
    56'h02_0003_0000_FC00, 56'h02_0003_0000_0A00, 56'h02_0003_0000_8000,
    56'h03_0008_0123_0000, 56'h03_0008_0123_0100, 56'h03_0008_0123_0200,
    56'h03_0008_0123_FF00, 56'h03_0008_0123_0500, 56'h03_0008_0123_1234,
    56'h03_0008_0123_F000, 56'h03_0008_0123_03FF,
    56'h04_0002_0600_0500, 56'h04_0002_0600_0700,
    56'h05_0002_00FF_03E6, 56'h05_0002_00FF_7FFF
  };

  ////////////////////////////////////////////////////////////
  // DUT signals and bookkeeping
  ////////////////////////////////////////////////////////////

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 READY;
  logic                 DATA_IN_ENABLE;
  logic                 DATA_OUT_ENABLE;
  logic [DATA_SIZE-1:0] MODULO_IN;
  logic [DATA_SIZE-1:0] SIZE_IN;
  logic [DATA_SIZE-1:0] DATA_IN;
  logic [DATA_SIZE-1:0] DATA_OUT;

  logic [55:0] rows[$];
  int          check_count;
  int          error_count;
  int          protocol_errors;
  int          oe_count;
  int          ready_count;
  int          cycle_count;
  logic        doe_prev;

  ntm_oneplus_top #(
    .DATA_SIZE(DATA_SIZE)
  ) dut0 (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .MODULO_IN      (MODULO_IN),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN        (DATA_IN),
    .DATA_OUT       (DATA_OUT)
  );

  always #50 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  // oneplus(x) = 1 + s, s clamped or (x + B)^2 / 16 in fixed point
  function automatic logic [DATA_SIZE-1:0] expected_oneplus(
    input logic [DATA_SIZE-1:0] data,
    input logic [DATA_SIZE-1:0] modulo
  );
    int x;
    int s;
    int y;
    x = int'($signed(data));
    if (x >= BOUND_FX) begin
      s = x;
    end else if (x <= -BOUND_FX) begin
      s = 0;
    end else begin
      s = ((x + BOUND_FX) * (x + BOUND_FX)) >>> (FRAC + ntm_fixed_pkg::CLAMP_SHIFT);
    end
    y = (ONE_FX + s) % (1 << DATA_SIZE);
    // Zero modulus leaves the sum as is
    if (modulo != '0) begin
      y = y % int'(modulo);
    end
    return DATA_SIZE'(y);
  endfunction

  task automatic check_value(
    input string                name,
    input logic [DATA_SIZE-1:0] actual,
    input logic [DATA_SIZE-1:0] expected
  );
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
    end
  endtask

  task automatic print_counts();
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             check_count, error_count, protocol_errors);
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic start_vector(input logic [DATA_SIZE-1:0] size,
                              input logic [DATA_SIZE-1:0] modulo);
    START     = 1'b1;
    SIZE_IN   = size;
    MODULO_IN = modulo;
    @(negedge CLK);
    START = 1'b0;
  endtask

  task automatic send_element(input logic [DATA_SIZE-1:0] data);
    DATA_IN_ENABLE = 1'b1;
    DATA_IN        = data;
    @(negedge CLK);
    DATA_IN_ENABLE = 1'b0;
  endtask

  // Latency varies, the cycle counter bounds the wait
  task automatic wait_result();
    while (DATA_OUT_ENABLE !== 1'b1) begin
      @(negedge CLK);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_ENABLE) begin
        oe_count++;
      end
      if (READY) begin
        ready_count++;
      end
      if (READY && !DATA_OUT_ENABLE) begin
        protocol_errors++;
        $display("READY came without DATA_OUT_ENABLE at t=%0t", $time);
      end
      if (DATA_OUT_ENABLE && doe_prev) begin
        protocol_errors++;
        $display("DATA_OUT_ENABLE stayed high for two cycles at t=%0t", $time);
      end
      doe_prev = DATA_OUT_ENABLE;
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
      print_counts();
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    integer               seed;
    logic [31:0]          r;
    logic [DATA_SIZE-1:0] rmod;
    logic [DATA_SIZE-1:0] rdata;
    logic [55:0]          row;
    logic [7:0]           prev_vec;
    logic                 last;
    int                   elem_idx;

    CLK             = 1'b0;
    RST             = 1'b1;
    START           = 1'b0;
    DATA_IN_ENABLE  = 1'b0;
    MODULO_IN       = '0;
    SIZE_IN         = '0;
    DATA_IN         = '0;
    check_count     = 0;
    error_count     = 0;
    protocol_errors = 0;
    oe_count        = 0;
    ready_count     = 0;
    cycle_count     = 0;
    doe_prev        = 1'b0;
    prev_vec        = 8'hFF;
    elem_idx        = 0;
    seed            = 32'hee0a;

    // Fixed table first, then random vectors of RANDOM_LEN elements
    for (int i = 0; i < TABLE_ROWS; i++) begin
      rows.push_back(STIM_TABLE[i]);
    end
    for (int v = 0; v < RANDOM_ROWS / RANDOM_LEN; v++) begin
      r    = $random(seed);
      // Variable shift spreads the modulus size, zero included
      rmod = r[15:0] >> r[19:16];
      for (int e = 0; e < RANDOM_LEN; e++) begin
        r = $random(seed);
        // About half the draws land in the middle branch
        if (r[16]) begin
          rdata = r[15:0];
        end else begin
          rdata = {{5{r[10]}}, r[10:0]};
        end
        rows.push_back({8'(6 + v), 16'(RANDOM_LEN), rmod, rdata});
      end
    end

    repeat (8) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Idle outputs after reset
    check_value("READY", DATA_SIZE'(READY), '0);
    check_value("DATA_OUT_ENABLE", DATA_SIZE'(DATA_OUT_ENABLE), '0);
    check_value("DATA_OUT", DATA_OUT, '0);

    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      if (row[55:48] != prev_vec) begin
        start_vector(row[47:32], row[31:16]);
        prev_vec = row[55:48];
        elem_idx = 0;
      end
      send_element(row[15:0]);
      wait_result();
      check_value("DATA_OUT", DATA_OUT, expected_oneplus(row[15:0], row[31:16]));
      // READY only with the last element of the vector
      last = (elem_idx == int'(row[47:32]) - 1);
      check_value("READY", DATA_SIZE'(READY), DATA_SIZE'(last));
      elem_idx++;
    end

    // Let stray strobes show up in the counts
    repeat (4) @(negedge CLK);
    @(posedge CLK);
    check_value("DATA_OUT_ENABLE count", DATA_SIZE'(oe_count), DATA_SIZE'(NUM_ELEMS));
    check_value("READY count", DATA_SIZE'(ready_count), DATA_SIZE'(NUM_VECTORS));

    print_counts();
    if (error_count == 0 && protocol_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/ntm_oneplus_props.sv */
/*
  Handshake properties of the vector controller
  Bound into every ntm_vector_oneplus_function instance
*/

`timescale 1ns/100ps

module ntm_oneplus_props (
  input logic       CLK,
  input logic       RST,
  input logic       READY,
  input logic       DATA_IN_ENABLE,
  input logic       DATA_OUT_ENABLE,
  input logic [1:0] ctrl_state
);

  ////////////////////////////////////////////////////////////
  // Output strobes
  ////////////////////////////////////////////////////////////

  // Result strobe is a single-cycle pulse
  doe_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else $error("DATA_OUT_ENABLE held for more than one cycle");

  // Vector done only rides on the last result
  ready_with_doe: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else $error("READY asserted without DATA_OUT_ENABLE");

  // Idle controller emits nothing next cycle
  no_doe_from_starter: assert property (@(posedge CLK) disable iff (RST)
    (ctrl_state == ntm_state_pkg::STARTER_STATE) |=> !DATA_OUT_ENABLE)
    else $error("DATA_OUT_ENABLE issued from STARTER");

  ////////////////////////////////////////////////////////////
  // Producer side
  ////////////////////////////////////////////////////////////

  din_not_while_pending: assert property (@(posedge CLK) disable iff (RST)
    (ctrl_state == ntm_state_pkg::ENDER_STATE) |-> !DATA_IN_ENABLE)
    else $error("DATA_IN_ENABLE pulsed while a result was pending");

endmodule

bind ntm_vector_oneplus_function ntm_oneplus_props props0 (
  .CLK            (CLK),
  .RST            (RST),
  .READY          (READY),
  .DATA_IN_ENABLE (DATA_IN_ENABLE),
  .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
  .ctrl_state     (oneplus_ctrl_fsm_int)
);

/* design/ntm_oneplus_top.sv */
/*
  Oneplus vector subsystem top, DATA_SIZE fixed here
  Elements are signed fixed point with 8 fraction bits
*/

`timescale 1ns/100ps

module ntm_oneplus_top #(
  parameter int DATA_SIZE = 16
) (
  // Global
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,
  input  logic                 DATA_IN_ENABLE,
  output logic                 DATA_OUT_ENABLE,

  // Data
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////////////////////////////////////////////
  // Vector oneplus function
  ////////////////////////////////////////////////////////////

  ntm_vector_oneplus_function #(
    .DATA_SIZE(DATA_SIZE)
  ) vector_oneplus_function (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .MODULO_IN      (MODULO_IN),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN        (DATA_IN),
    .DATA_OUT       (DATA_OUT)
  );

endmodule

/* oneplus/ntm_vector_oneplus_function.sv */
/*
  Walks SIZE_IN elements through the scalar oneplus unit one at a time
  SIZE_IN must be at least 1 and stays stable with MODULO_IN for the whole vector
  The consumer must take every DATA_OUT_ENABLE pulse as there is no back-pressure
*/

`timescale 1ns/100ps

module ntm_vector_oneplus_function #(
  parameter int DATA_SIZE = 16
) (
  // Global
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,
  input  logic                 DATA_IN_ENABLE,
  output logic                 DATA_OUT_ENABLE,

  // Data
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Controller FSM
  ntm_state_pkg::vector_state_t oneplus_ctrl_fsm_int;

  // Element index within the current vector
  logic [DATA_SIZE-1:0] index_loop;

  // Scalar unit handshake
  logic                 scalar_start;
  logic                 scalar_ready;

  // Latched operands for the scalar unit
  logic [DATA_SIZE-1:0] scalar_modulo;
  logic [DATA_SIZE-1:0] scalar_data_in;
  logic [DATA_SIZE-1:0] scalar_data_out;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      oneplus_ctrl_fsm_int <= ntm_state_pkg::STARTER_STATE;
      index_loop           <= '0;
      scalar_start         <= 1'b0;
      READY                <= 1'b0;
      DATA_OUT_ENABLE      <= 1'b0;
      DATA_OUT             <= '0;
    end else begin
      // Strobes last a single cycle
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;

      case (oneplus_ctrl_fsm_int)
        ntm_state_pkg::STARTER_STATE: begin
          // New vector restarts the index
          if (START) begin
            index_loop           <= '0;
            oneplus_ctrl_fsm_int <= ntm_state_pkg::INPUT_STATE;
          end
        end

        ntm_state_pkg::INPUT_STATE: begin
          // Wait for the producer
          if (DATA_IN_ENABLE) begin
            scalar_start         <= 1'b1;
            oneplus_ctrl_fsm_int <= ntm_state_pkg::ENDER_STATE;
          end
        end

        ntm_state_pkg::ENDER_STATE: begin
          // Extra DATA_IN_ENABLE pulses here are dropped
          if (scalar_ready) begin
            DATA_OUT        <= scalar_data_out;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_loop == SIZE_IN - DATA_SIZE'(1)) begin
              // READY rides with the DATA_OUT_ENABLE of the last element
              READY                <= 1'b1;
              oneplus_ctrl_fsm_int <= ntm_state_pkg::STARTER_STATE;
            end else begin
              index_loop           <= index_loop + DATA_SIZE'(1);
              oneplus_ctrl_fsm_int <= ntm_state_pkg::INPUT_STATE;
            end
          end
        end

        default: begin
          oneplus_ctrl_fsm_int <= ntm_state_pkg::STARTER_STATE;
        end
      endcase
    end
  end

  // Operand capture when the producer strobes
  always_ff @(posedge CLK) begin
    if (oneplus_ctrl_fsm_int == ntm_state_pkg::INPUT_STATE && DATA_IN_ENABLE) begin
      scalar_modulo  <= MODULO_IN;
      scalar_data_in <= DATA_IN;
    end
  end

  ////////////////////////////////////////////////////////////
  // Scalar oneplus unit
  ////////////////////////////////////////////////////////////

  ntm_scalar_oneplus_function #(
    .DATA_SIZE(DATA_SIZE)
  ) scalar_oneplus_function (
    .CLK      (CLK),
    .RST      (RST),
    .START    (scalar_start),
    .READY    (scalar_ready),
    .MODULO_IN(scalar_modulo),
    .DATA_IN  (scalar_data_in),
    .DATA_OUT (scalar_data_out)
  );

endmodule

/* oneplus/ntm_scalar_oneplus_function.sv */
/*
  Scalar oneplus with the quadratic softplus approximation
  Result ONE_FX + s wraps at DATA_SIZE bits before the modular reduction
  MODULO_IN of zero gives the unreduced sum
*/

`timescale 1ns/100ps

module ntm_scalar_oneplus_function #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////////////////////////////////////////////
  // Constants scaled to DATA_SIZE
  ////////////////////////////////////////////////////////////

  localparam logic signed [DATA_SIZE-1:0] BOUND_FX =
    DATA_SIZE'(ntm_fixed_pkg::BOUND_INT <<< ntm_fixed_pkg::FRAC_BITS);
  localparam logic signed [DATA_SIZE-1:0] NEG_BOUND_FX = -BOUND_FX;
  localparam logic [DATA_SIZE-1:0] ONE_FX =
    DATA_SIZE'(ntm_fixed_pkg::ONE_INT << ntm_fixed_pkg::FRAC_BITS);

  // Rescale the square and divide by 16
  localparam int SQUARE_SHIFT = ntm_fixed_pkg::FRAC_BITS + ntm_fixed_pkg::CLAMP_SHIFT;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_state_pkg::scalar_state_t scalar_fsm;

  logic signed [DATA_SIZE-1:0]   x_reg;
  logic [DATA_SIZE-1:0]          modulo_reg;
  logic [DATA_SIZE-1:0]          soft_reg;
  logic [DATA_SIZE-1:0]          sum_reg;

  // Multiplier side, squares x + B
  logic                          mul_start;
  logic                          mul_ready;
  logic [DATA_SIZE-1:0]          mul_operand;
  logic [2*DATA_SIZE-1:0]        mul_product;

  // Reducer side
  logic                          red_start;
  logic                          red_ready;
  logic [DATA_SIZE-1:0]          red_out;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      scalar_fsm <= ntm_state_pkg::SCALAR_IDLE;
      mul_start  <= 1'b0;
      red_start  <= 1'b0;
      READY      <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      red_start <= 1'b0;
      READY     <= 1'b0;

      case (scalar_fsm)
        ntm_state_pkg::SCALAR_IDLE: begin
          if (START) begin
            scalar_fsm <= ntm_state_pkg::SCALAR_CLAMP;
          end
        end

        ntm_state_pkg::SCALAR_CLAMP: begin
          // Saturated inputs skip the multiplier
          if (x_reg >= BOUND_FX || x_reg <= NEG_BOUND_FX) begin
            scalar_fsm <= ntm_state_pkg::SCALAR_SUM;
          end else begin
            mul_start  <= 1'b1;
            scalar_fsm <= ntm_state_pkg::SCALAR_SQUARE;
          end
        end

        ntm_state_pkg::SCALAR_SQUARE: begin
          if (mul_ready) begin
            scalar_fsm <= ntm_state_pkg::SCALAR_SUM;
          end
        end

        ntm_state_pkg::SCALAR_SUM: begin
          red_start  <= 1'b1;
          scalar_fsm <= ntm_state_pkg::SCALAR_REDUCE;
        end

        ntm_state_pkg::SCALAR_REDUCE: begin
          if (red_ready) begin
            READY      <= 1'b1;
            scalar_fsm <= ntm_state_pkg::SCALAR_IDLE;
          end
        end

        default: begin
          scalar_fsm <= ntm_state_pkg::SCALAR_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Operand capture
    if (scalar_fsm == ntm_state_pkg::SCALAR_IDLE && START) begin
      x_reg      <= DATA_IN;
      modulo_reg <= MODULO_IN;
    end

    // Clamp branches, s = x above B and s = 0 below -B
    if (scalar_fsm == ntm_state_pkg::SCALAR_CLAMP) begin
      mul_operand <= DATA_SIZE'(x_reg + BOUND_FX);
      if (x_reg >= BOUND_FX) begin
        soft_reg <= x_reg;
      end else if (x_reg <= NEG_BOUND_FX) begin
        soft_reg <= '0;
      end
    end

    // Middle branch, (x + B)^2 >> (FRAC_BITS + 4)
    if (scalar_fsm == ntm_state_pkg::SCALAR_SQUARE && mul_ready) begin
      soft_reg <= DATA_SIZE'(mul_product >> SQUARE_SHIFT);
    end

    // oneplus = 1 + softplus, unsigned wrap
    if (scalar_fsm == ntm_state_pkg::SCALAR_SUM) begin
      sum_reg <= ONE_FX + soft_reg;
    end

    if (scalar_fsm == ntm_state_pkg::SCALAR_REDUCE && red_ready) begin
      DATA_OUT <= red_out;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helper units
  ////////////////////////////////////////////////////////////

  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) scalar_multiplier (
    .CLK         (CLK),
    .RST         (RST),
    .START       (mul_start),
    .READY       (mul_ready),
    .MULTIPLICAND(mul_operand),
    .MULTIPLIER  (mul_operand),
    .PRODUCT     (mul_product)
  );

  ntm_scalar_modular_reduce #(
    .DATA_SIZE(DATA_SIZE)
  ) scalar_modular_reduce (
    .CLK      (CLK),
    .RST      (RST),
    .START    (red_start),
    .READY    (red_ready),
    .MODULO_IN(modulo_reg),
    .DATA_IN  (sum_reg),
    .DATA_OUT (red_out)
  );

endmodule

/* design/ntm_scalar_modular_reduce.sv */
/*
  Restoring remainder DATA_IN mod MODULO_IN, one dividend bit per cycle
  Zero modulus passes DATA_IN through with READY one cycle after START
*/

`timescale 1ns/100ps

module ntm_scalar_modular_reduce #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  localparam int CNT_W = $clog2(DATA_SIZE);

  ntm_state_pkg::op_state_t red_fsm;

  logic [CNT_W-1:0]     bit_count;
  logic [DATA_SIZE-1:0] dividend_reg;
  logic [DATA_SIZE-1:0] modulo_reg;

  // Partial remainder with the next dividend bit shifted in
  logic [DATA_SIZE:0]   rem_shift;

  assign rem_shift = {DATA_OUT, dividend_reg[DATA_SIZE-1]};

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      red_fsm   <= ntm_state_pkg::OP_IDLE;
      bit_count <= '0;
      READY     <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (red_fsm)
        ntm_state_pkg::OP_IDLE: begin
          if (START) begin
            bit_count <= '0;
            // Bypass when there is nothing to reduce by
            if (MODULO_IN == '0) begin
              READY   <= 1'b1;
              red_fsm <= ntm_state_pkg::OP_DONE;
            end else begin
              red_fsm <= ntm_state_pkg::OP_RUN;
            end
          end
        end
        ntm_state_pkg::OP_RUN: begin
          bit_count <= bit_count + CNT_W'(1);
          if (bit_count == CNT_W'(DATA_SIZE - 1)) begin
            READY   <= 1'b1;
            red_fsm <= ntm_state_pkg::OP_DONE;
          end
        end
        default: begin
          red_fsm <= ntm_state_pkg::OP_IDLE;
        end
      endcase
    end
  end

  // Remainder datapath, DATA_OUT doubles as the partial remainder
  always_ff @(posedge CLK) begin
    if (red_fsm == ntm_state_pkg::OP_IDLE && START) begin
      dividend_reg <= DATA_IN;
      modulo_reg   <= MODULO_IN;
      DATA_OUT     <= (MODULO_IN == '0) ? DATA_IN : '0;
    end else if (red_fsm == ntm_state_pkg::OP_RUN) begin
      dividend_reg <= dividend_reg << 1;
      // Restore unless the trial subtraction fits
      if (rem_shift >= {1'b0, modulo_reg}) begin
        DATA_OUT <= DATA_SIZE'(rem_shift - {1'b0, modulo_reg});
      end else begin
        DATA_OUT <= DATA_SIZE'(rem_shift);
      end
    end
  end

endmodule

/* design/ntm_scalar_multiplier.sv */
/*
  Unsigned shift-add multiplier, one multiplier bit per cycle
  READY pulses DATA_SIZE + 1 cycles after START, PRODUCT held until next START
*/

`timescale 1ns/100ps

module ntm_scalar_multiplier #(
  parameter int DATA_SIZE = 16
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  output logic                   READY,
  input  logic [DATA_SIZE-1:0]   MULTIPLICAND,
  input  logic [DATA_SIZE-1:0]   MULTIPLIER,
  output logic [2*DATA_SIZE-1:0] PRODUCT
);

  localparam int CNT_W = $clog2(DATA_SIZE);

  ntm_state_pkg::op_state_t mul_fsm;

  logic [CNT_W-1:0]       bit_count;
  logic [2*DATA_SIZE-1:0] mcand_reg;
  logic [DATA_SIZE-1:0]   mplier_reg;

  // Sequencing and bit counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mul_fsm   <= ntm_state_pkg::OP_IDLE;
      bit_count <= '0;
      READY     <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (mul_fsm)
        ntm_state_pkg::OP_IDLE: begin
          if (START) begin
            bit_count <= '0;
            mul_fsm   <= ntm_state_pkg::OP_RUN;
          end
        end
        ntm_state_pkg::OP_RUN: begin
          bit_count <= bit_count + CNT_W'(1);
          // Last step lands together with READY
          if (bit_count == CNT_W'(DATA_SIZE - 1)) begin
            READY   <= 1'b1;
            mul_fsm <= ntm_state_pkg::OP_DONE;
          end
        end
        default: begin
          mul_fsm <= ntm_state_pkg::OP_IDLE;
        end
      endcase
    end
  end

  // Shift-add datapath
  always_ff @(posedge CLK) begin
    if (mul_fsm == ntm_state_pkg::OP_IDLE && START) begin
      mcand_reg  <= {{DATA_SIZE{1'b0}}, MULTIPLICAND};
      mplier_reg <= MULTIPLIER;
      PRODUCT    <= '0;
    end else if (mul_fsm == ntm_state_pkg::OP_RUN) begin
      if (mplier_reg[0]) begin
        PRODUCT <= PRODUCT + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

endmodule

/* common/ntm_state_pkg.sv */
/*
  State encodings of the oneplus sequencers and helper units
*/

package ntm_state_pkg;

  // Vector controller, one element in flight at a time
  typedef enum logic [1:0] {
    STARTER_STATE = 2'd0,
    INPUT_STATE   = 2'd1,
    ENDER_STATE   = 2'd2
  } vector_state_t;

  // Scalar oneplus sequencer
  typedef enum logic [2:0] {
    SCALAR_IDLE   = 3'd0,
    SCALAR_CLAMP  = 3'd1,
    SCALAR_SQUARE = 3'd2,
    SCALAR_SUM    = 3'd3,
    SCALAR_REDUCE = 3'd4
  } scalar_state_t;

  // Iterative multiplier and remainder unit
  typedef enum logic [1:0] {
    OP_IDLE = 2'd0,
    OP_RUN  = 2'd1,
    OP_DONE = 2'd2
  } op_state_t;

endpackage

/* common/ntm_fixed_pkg.sv */
/*
  Fixed-point constants for the oneplus datapath
  Values are plain integers, each module scales them to its own DATA_SIZE
*/

package ntm_fixed_pkg;

  ////////////////////////////////////////////////////////////
  // Number format
  ////////////////////////////////////////////////////////////

  // Fraction bits of every signed element
  localparam int FRAC_BITS = 8;

  // Extra right shift for the division by 16 in (x+B)^2/16
  localparam int CLAMP_SHIFT = 4;

  ////////////////////////////////////////////////////////////
  // Integer constants before scaling
  ////////////////////////////////////////////////////////////

  // Clamp bound B of the quadratic softplus approximation
  localparam int BOUND_INT = 4;

  // The constant one added by oneplus
  localparam int ONE_INT = 1;

endpackage
